//--- build.f
+incdir+rtl
rtl/axi_burst_pkg.sv
rtl/write_cmd_planner.sv
rtl/axi_write_channel.sv
rtl/axi_read_channel.sv
rtl/axi_burst_master.sv
verif/axi_burst_assertions.sv
verif/tb_axi_burst_master.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_axi_burst_master
RTL_TOP   := axi_burst_master
FILELIST  := build.f
LOG       := sim.log
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_axi_burst_master.sv
`timescale 1ns/10ps

module tb_axi_burst_master;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 9;
    localparam logic [19:0] MARK_PAGE = 20'h00005;   // slave answers SLVERR in this page

    logic                         aclk;
    logic                         aresetn;
    logic                         w_start;
    axi_burst_pkg::user_cmd_t     w_cmd;
    logic                         w_free;
    axi_burst_pkg::cmd_err_t      w_cmd_error;
    axi_burst_pkg::axi_resp_e     w_status;
    axi_burst_pkg::data_t         w_data = '0;
    axi_burst_pkg::strb_t         w_strb;
    axi_burst_pkg::fifo_cnt_t     w_fifo_cnt = '0;
    logic                         w_pop;
    logic                         r_start;
    axi_burst_pkg::user_cmd_t     r_cmd;
    logic                         r_free;
    axi_burst_pkg::axi_resp_e     r_status;
    axi_burst_pkg::data_t         r_data;
    logic                         r_fifo_full = 1'b0;
    logic                         r_push;
    axi_burst_pkg::aw_req_t       aw;
    logic                         awvalid;
    logic                         awready = 1'b0;
    axi_burst_pkg::w_beat_t       w;
    logic                         wvalid;
    logic                         wready = 1'b0;
    axi_burst_pkg::axi_resp_e     bresp = axi_burst_pkg::OKAY;
    logic                         bvalid = 1'b0;
    logic                         bready;
    axi_burst_pkg::aw_req_t       ar;
    logic                         arvalid;
    logic                         arready = 1'b0;
    axi_burst_pkg::data_t         rdata = '0;
    axi_burst_pkg::axi_resp_e     rresp = axi_burst_pkg::OKAY;
    logic                         rlast = 1'b0;
    logic                         rvalid = 1'b0;
    logic                         rready;

    integer                       seed = 32'h9649;
    string                        test_name = "reset";
    axi_burst_pkg::data_t         mem [axi_burst_pkg::addr_t];   // sparse slave memory
    axi_burst_pkg::data_t         wfifo [$];
    axi_burst_pkg::data_t         rd_got [$];
    axi_burst_pkg::aw_req_t       aw_log [$];
    axi_burst_pkg::aw_req_t       ar_log [$];
    axi_burst_pkg::addr_t         waddr;
    axi_burst_pkg::addr_t         raddr;
    axi_burst_pkg::len_t          rleft;
    int                           beats_written;
    logic                         r_busy = 1'b0;
    logic                         b_pend = 1'b0;
    logic                         b_err = 1'b0;
    logic                         b_xfer;
    logic                         r_xfer;

    axi_burst_master dut (.*);

    // user data for a beat, a function of its full target address
    function automatic axi_burst_pkg::data_t beat_pattern(input axi_burst_pkg::addr_t a);
        return {a ^ 32'hc3a5_0f96, ~a};
    endfunction

    function automatic logic chance(input int pct);
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % 100) < pct;
    endfunction

    task automatic run_error(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else
        begin
            $display("Fail %s %s expected %0h actual %0h", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_wfifo(input axi_burst_pkg::addr_t base, input int beats);
        for (int i = 0; i < beats; i++)
            wfifo.push_back(beat_pattern(base + 32'(8 * i)));
        repeat (2) @(posedge aclk);     // let the count reach the DUT
    endtask

    task automatic run_write(input axi_burst_pkg::addr_t addr, input axi_burst_pkg::len_t len);
        aw_log.delete();
        beats_written = 0;
        @(posedge aclk);
        #1;
        w_start    = 1'b1;
        w_cmd.addr = addr;
        w_cmd.len  = len;
        do @(posedge aclk); while (!w_free);
        #1;
        w_start = 1'b0;
        do @(posedge aclk); while (!w_free);    // free again once the command is over
    endtask

    task automatic run_read(input axi_burst_pkg::addr_t addr, input axi_burst_pkg::len_t len);
        ar_log.delete();
        rd_got.delete();
        @(posedge aclk);
        #1;
        r_start    = 1'b1;
        r_cmd.addr = addr;
        r_cmd.len  = len;
        do @(posedge aclk); while (!r_free);
        #1;
        r_start = 1'b0;
        do @(posedge aclk); while (!r_free);
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial
    begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        run_error("watchdog expired before the test list completed");
    end

    always @(posedge aclk)
    begin
        if (dut.u_assert.fail_cnt != 0)
            run_error("a protocol assertion failed");
    end

    // AXI slave and user FIFOs, sampled on the edge and driven 1 ns later
    always @(posedge aclk)
    begin
        b_xfer = bvalid && bready;
        r_xfer = rvalid && rready;
        if (awvalid && awready)
        begin
            aw_log.push_back(aw);
            check_eq("aw size", 3, aw.size);    // 8 bytes per beat
            check_eq("aw burst", 1, aw.burst);  // INCR
            waddr = aw.addr;
            b_err = (aw.addr[31:12] == MARK_PAGE);
        end
        if (wvalid && wready)
        begin
            check_eq("wdata", beat_pattern(waddr), w.data);
            check_eq("wstrb", 8'hff, w.strb);
            mem[waddr] = w.data;
            waddr = waddr + 32'd8;
            beats_written++;
            if (w.last)
                b_pend = 1'b1;
        end
        // the FIFO head moves only on the DUT's pop
        if (w_pop)
        begin
            assert (wfifo.size() > 0) else run_error("write FIFO popped while empty");
            void'(wfifo.pop_front());
        end
        if (arvalid && arready)
        begin
            ar_log.push_back(ar);
            check_eq("ar size", 3, ar.size);
            check_eq("ar burst", 1, ar.burst);
            raddr  = ar.addr;
            rleft  = ar.len;
            r_busy = 1'b1;
        end
        if (r_push)
            rd_got.push_back(r_data);
        if (r_xfer)
        begin
            raddr = raddr + 32'd8;
            if (rlast)
                r_busy = 1'b0;
            else
                rleft = rleft - 1'b1;
        end
        #1;
        awready     = chance(70);
        wready      = chance(70);
        arready     = chance(50);
        r_fifo_full = chance(30);   // read FIFO full on random cycles
        if (b_xfer)
            bvalid = 1'b0;
        if (b_pend)
        begin
            bvalid = 1'b1;
            bresp  = b_err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
            b_pend = 1'b0;
        end
        if (r_xfer)
            rvalid = 1'b0;
        if (r_busy && !rvalid && chance(60))
        begin
            rvalid = 1'b1;
            rdata  = mem.exists(raddr) ? mem[raddr] : {~raddr, raddr};
            rresp  = (raddr[31:12] == MARK_PAGE) ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
            rlast  = (rleft == '0);
        end
        w_fifo_cnt = axi_burst_pkg::fifo_cnt_t'(wfifo.size());
        w_data     = (wfifo.size() > 0) ? wfifo[0] : '0;
    end

    initial
    begin
        aresetn = 1'b0;
        w_start = 1'b0;
        w_cmd   = '0;
        w_strb  = 8'hff;
        r_start = 1'b0;
        r_cmd   = '0;
        repeat (16) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        check_eq("w_free", 1, w_free);
        check_eq("r_free", 1, r_free);
        check_eq("w_cmd_error", 0, w_cmd_error);
        check_eq("w_status", axi_burst_pkg::OKAY, w_status);
        check_eq("r_status", axi_burst_pkg::OKAY, r_status);
        check_eq("valids", 0, {awvalid, wvalid, arvalid, w_pop, r_push});

        test_name = "aligned_write";
        fill_wfifo(32'h0000_1100, 8);
        run_write(32'h0000_1100, 8'd7);
        check_eq("aw count", 1, aw_log.size());
        check_eq("aw addr", 32'h0000_1100, aw_log[0].addr);
        check_eq("aw len", 7, aw_log[0].len);
        check_eq("beats", 8, beats_written);

        test_name = "page_cross";
        fill_wfifo(32'h0000_2fc0, 16);
        run_write(32'h0000_2fc0, 8'd15);
        check_eq("aw count", 2, aw_log.size());
        check_eq("aw0 addr", 32'h0000_2fc0, aw_log[0].addr);
        check_eq("aw0 len", 7, aw_log[0].len);      // (0x1000 - 0xfc0) / 8 beats to the page end
        check_eq("aw1 addr", 32'h0000_3000, aw_log[1].addr);
        check_eq("aw1 len", 7, aw_log[1].len);
        check_eq("beats", 16, beats_written);

        test_name = "misaligned";
        fill_wfifo(32'h0000_4004, 4);
        run_write(32'h0000_4004, 8'd3);
        check_eq("w_cmd_error", 2'b01, w_cmd_error);
        repeat (4) @(posedge aclk);
        check_eq("aw count", 0, aw_log.size());
        wfifo.delete();

        test_name = "short_data";
        fill_wfifo(32'h0000_4000, 4);
        run_write(32'h0000_4000, 8'd7);
        check_eq("w_cmd_error", 2'b10, w_cmd_error);
        repeat (4) @(posedge aclk);
        check_eq("aw count", 0, aw_log.size());
        wfifo.delete();

        test_name = "write_slverr";
        fill_wfifo(32'h0000_5040, 4);
        run_write(32'h0000_5040, 8'd3);
        check_eq("w_status", axi_burst_pkg::SLVERR, w_status);

        test_name = "write_okay";
        fill_wfifo(32'h0000_6000, 4);
        run_write(32'h0000_6000, 8'd3);
        check_eq("w_status", axi_burst_pkg::OKAY, w_status);

        test_name = "read_slverr";
        run_read(32'h0000_5040, 8'd3);
        check_eq("ar count", 1, ar_log.size());
        check_eq("ar len", 3, ar_log[0].len);
        check_eq("read beats", 4, rd_got.size());
        for (int i = 0; i < 4; i++)
            check_eq("rdata", beat_pattern(32'h0000_5040 + 32'(8 * i)), rd_got[i]);
        check_eq("r_status", axi_burst_pkg::SLVERR, r_status);

        test_name = "read";
        run_read(32'h0000_1100, 8'd7);
        check_eq("ar count", 1, ar_log.size());
        check_eq("ar addr", 32'h0000_1100, ar_log[0].addr);
        check_eq("ar len", 7, ar_log[0].len);
        check_eq("read beats", 8, rd_got.size());
        for (int i = 0; i < 8; i++)
            check_eq("rdata", beat_pattern(32'h0000_1100 + 32'(8 * i)), rd_got[i]);
        check_eq("r_status", axi_burst_pkg::OKAY, r_status);

        repeat (4) @(posedge aclk);
        if (dut.u_assert.fail_cnt == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            run_error("a protocol assertion failed");
        end
    end

endmodule

//--- verif/axi_burst_assertions.sv
`timescale 1ns/10ps

`include "axi_burst_consts.svh"

module axi_burst_assertions
(
    input  logic                          aclk,
    input  logic                          aresetn,
    input  axi_burst_pkg::aw_req_t        aw,
    input  logic                          awvalid,
    input  logic                          awready,
    input  axi_burst_pkg::w_beat_t        w,
    input  logic                          wvalid,
    input  logic                          wready,
    input  logic                          bready,
    input  axi_burst_pkg::aw_req_t        ar,
    input  logic                          arvalid,
    input  logic                          arready,
    input  logic                          rready,
    input  logic                          r_fifo_full,
    input  logic                          w_pop,
    input  logic                          r_push,
    input  logic                          w_free,
    input  logic                          r_free,
    input  axi_burst_pkg::cmd_err_t       w_cmd_error,
    input  axi_burst_pkg::axi_resp_e      w_status,
    input  axi_burst_pkg::axi_resp_e      r_status
);

    localparam int END_W = `PAGE_SHIFT + 1;

    int unsigned             fail_cnt = 0;
    axi_burst_pkg::len_t     aw_len_q;
    axi_burst_pkg::len_t     wbeat;
    logic [END_W-1:0]        aw_end;    // page offset just past the burst

    assign aw_end = END_W'(aw.addr[`PAGE_SHIFT-1:0])
                  + ((END_W'(aw.len) + END_W'(1)) << `AXI_BEAT_SHIFT);

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            wbeat <= '0;
        else if (awvalid && awready)
        begin
            aw_len_q <= aw.len;
            wbeat    <= '0;
        end
        else if (wvalid && wready)
            wbeat <= wbeat + 1'b1;
    end

    reset_values: assert property (@(posedge aclk) !aresetn |=>
        (!awvalid && !wvalid && !arvalid && !bready && !rready && !w_pop && !r_push
         && w_free && r_free && w_cmd_error == '0
         && w_status == axi_burst_pkg::OKAY && r_status == axi_burst_pkg::OKAY))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("outputs not at their reset values");
    end

    aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(aw))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("AW changed before awready");
    end

    w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(w))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("W changed before wready");
    end

    ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("AR changed before arready");
    end

    // a burst may end exactly on the boundary
    aw_page_safe: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid |-> aw_end <= END_W'(`PAGE_BYTES))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("AW burst crosses a page");
    end

    wlast_pos: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid |-> (w.last == (wbeat == aw_len_q)))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("wlast on the wrong beat");
    end

    rd_stall: assert property (@(posedge aclk) disable iff (!aresetn)
        r_fifo_full |-> !rready)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("rready high while the read FIFO is full");
    end

endmodule

bind axi_burst_master axi_burst_assertions u_assert (.*);

//--- rtl/axi_burst_master.sv
`timescale 1ns/10ps

module axi_burst_master
(
    input  logic                          aclk,
    input  logic                          aresetn,
    // write command
    input  logic                          w_start,
    input  axi_burst_pkg::user_cmd_t      w_cmd,
    output logic                          w_free,
    output axi_burst_pkg::cmd_err_t       w_cmd_error,
    output axi_burst_pkg::axi_resp_e      w_status,
    // write data FIFO
    input  axi_burst_pkg::data_t          w_data,
    input  axi_burst_pkg::strb_t          w_strb,
    input  axi_burst_pkg::fifo_cnt_t      w_fifo_cnt,
    output logic                          w_pop,
    // read command
    input  logic                          r_start,
    input  axi_burst_pkg::user_cmd_t      r_cmd,
    output logic                          r_free,
    output axi_burst_pkg::axi_resp_e      r_status,
    // read data FIFO
    output axi_burst_pkg::data_t          r_data,
    input  logic                          r_fifo_full,
    output logic                          r_push,
    // AXI4 master
    output axi_burst_pkg::aw_req_t        aw,
    output logic                          awvalid,
    input  logic                          awready,
    output axi_burst_pkg::w_beat_t        w,
    output logic                          wvalid,
    input  logic                          wready,
    input  axi_burst_pkg::axi_resp_e      bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output axi_burst_pkg::aw_req_t        ar,
    output logic                          arvalid,
    input  logic                          arready,
    input  axi_burst_pkg::data_t          rdata,
    input  axi_burst_pkg::axi_resp_e      rresp,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready
);

    // planner to write channel
    axi_burst_pkg::burst_seg_t  seg;
    logic                       seg_valid;
    logic                       seg_ready;
    logic                       seg_done;
    axi_burst_pkg::axi_resp_e   seg_resp;

    write_cmd_planner u_planner (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .w_start     (w_start),
        .w_cmd       (w_cmd),
        .w_fifo_cnt  (w_fifo_cnt),
        .seg_ready   (seg_ready),
        .seg_done    (seg_done),
        .seg_resp    (seg_resp),
        .w_free      (w_free),
        .w_cmd_error (w_cmd_error),
        .w_status    (w_status),
        .seg         (seg),
        .seg_valid   (seg_valid)
    );

    axi_write_channel u_wr_chan (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_ready (seg_ready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w_data    (w_data),
        .w_strb    (w_strb),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .w_pop     (w_pop),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .seg_done  (seg_done),
        .seg_resp  (seg_resp)
    );

    axi_read_channel u_rd_chan (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .r_start     (r_start),
        .r_cmd       (r_cmd),
        .r_free      (r_free),
        .r_status    (r_status),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rlast       (rlast),
        .rready      (rready),
        .r_fifo_full (r_fifo_full),
        .r_data      (r_data),
        .r_push      (r_push)
    );

endmodule

//--- rtl/axi_read_channel.sv
`timescale 1ns/10ps

`include "axi_burst_consts.svh"

module axi_read_channel
(
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          r_start,
    input  axi_burst_pkg::user_cmd_t      r_cmd,
    output logic                          r_free,
    output axi_burst_pkg::axi_resp_e      r_status,
    // AR
    output axi_burst_pkg::aw_req_t        ar,
    output logic                          arvalid,
    input  logic                          arready,
    // R
    input  axi_burst_pkg::data_t          rdata,
    input  axi_burst_pkg::axi_resp_e      rresp,
    input  logic                          rvalid,
    input  logic                          rlast,
    output logic                          rready,
    // user FIFO side
    input  logic                          r_fifo_full,
    output axi_burst_pkg::data_t          r_data,
    output logic                          r_push
);

    axi_burst_pkg::rd_state_e   state;
    axi_burst_pkg::rd_state_e   state_nxt;
    axi_burst_pkg::user_cmd_t   cmd_q;
    logic                       accept;

    assign r_free  = (state == axi_burst_pkg::R_IDLE);
    assign accept  = r_start && r_free;
    assign arvalid = (state == axi_burst_pkg::R_ADDR);
    assign rready  = (state == axi_burst_pkg::R_DATA) && !r_fifo_full;  // stall while FIFO full
    assign r_push  = rvalid && rready;
    assign r_data  = rdata;

    // user keeps reads inside one page, so one burst per command
    always_comb
    begin
        ar.addr  = cmd_q.addr;
        ar.len   = cmd_q.len;
        ar.size  = 3'(`AXI_BEAT_SHIFT);
        ar.burst = `AXI_BURST_INCR;
        ar.cache = `AXI_CACHE_DEFAULT;
        ar.prot  = `AXI_PROT_DEFAULT;
    end

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            axi_burst_pkg::R_IDLE:
            begin
                if (r_start)
                    state_nxt = axi_burst_pkg::R_ADDR;
            end
            axi_burst_pkg::R_ADDR:
            begin
                if (arready)
                    state_nxt = axi_burst_pkg::R_DATA;
            end
            axi_burst_pkg::R_DATA:
            begin
                if (r_push && rlast)
                    state_nxt = axi_burst_pkg::R_IDLE;
            end
            default: state_nxt = axi_burst_pkg::R_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state    <= axi_burst_pkg::R_IDLE;
            r_status <= axi_burst_pkg::OKAY;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
                r_status <= axi_burst_pkg::OKAY;
            else if (r_push && r_status == axi_burst_pkg::OKAY)
                r_status <= rresp;  // keeps the first error
        end
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
            cmd_q <= r_cmd;
    end

endmodule

//--- rtl/axi_write_channel.sv
`timescale 1ns/10ps

`include "axi_burst_consts.svh"

module axi_write_channel
(
    input  logic                          aclk,
    input  logic                          aresetn,
    input  axi_burst_pkg::burst_seg_t     seg,
    input  logic                          seg_valid,
    output logic                          seg_ready,
    // AW
    output axi_burst_pkg::aw_req_t        aw,
    output logic                          awvalid,
    input  logic                          awready,
    // W, fed straight from the user FIFO head
    input  axi_burst_pkg::data_t          w_data,
    input  axi_burst_pkg::strb_t          w_strb,
    output axi_burst_pkg::w_beat_t        w,
    output logic                          wvalid,
    input  logic                          wready,
    output logic                          w_pop,
    // B
    input  axi_burst_pkg::axi_resp_e      bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic                          seg_done,
    output axi_burst_pkg::axi_resp_e      seg_resp
);

    axi_burst_pkg::wr_state_e   state;
    axi_burst_pkg::wr_state_e   state_nxt;
    axi_burst_pkg::burst_seg_t  seg_q;
    axi_burst_pkg::len_t        beat_cnt;
    logic                       last_beat;

    assign seg_ready = (state == axi_burst_pkg::W_IDLE);
    assign awvalid   = (state == axi_burst_pkg::W_ADDR);
    assign wvalid    = (state == axi_burst_pkg::W_DATA);  // data was checked up front
    assign bready    = (state == axi_burst_pkg::W_RESP);
    assign last_beat = (beat_cnt == seg_q.len);
    assign w_pop     = wvalid && wready;
    assign seg_done  = bready && bvalid;
    assign seg_resp  = bresp;

    always_comb
    begin
        aw.addr  = seg_q.addr;
        aw.len   = seg_q.len;
        aw.size  = 3'(`AXI_BEAT_SHIFT);
        aw.burst = `AXI_BURST_INCR;
        aw.cache = `AXI_CACHE_DEFAULT;
        aw.prot  = `AXI_PROT_DEFAULT;

        w.data = w_data;
        w.strb = w_strb;
        w.last = last_beat;
    end

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            axi_burst_pkg::W_IDLE:
            begin
                if (seg_valid)
                    state_nxt = axi_burst_pkg::W_ADDR;
            end
            axi_burst_pkg::W_ADDR:
            begin
                if (awready)
                    state_nxt = axi_burst_pkg::W_DATA;
            end
            axi_burst_pkg::W_DATA:
            begin
                if (wready && last_beat)
                    state_nxt = axi_burst_pkg::W_RESP;
            end
            axi_burst_pkg::W_RESP:
            begin
                if (bvalid)
                    state_nxt = axi_burst_pkg::W_IDLE;
            end
            default: state_nxt = axi_burst_pkg::W_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state    <= axi_burst_pkg::W_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state != axi_burst_pkg::W_DATA)
                beat_cnt <= '0;
            else if (wready)
                beat_cnt <= beat_cnt + 1'b1;    // one per accepted beat
        end
    end

    // burst held here for the whole AW/W/B sequence
    always_ff @(posedge aclk)
    begin
        if (seg_valid && seg_ready)
            seg_q <= seg;
    end

endmodule

//--- rtl/write_cmd_planner.sv
`timescale 1ns/10ps

`include "axi_burst_consts.svh"

module write_cmd_planner
(
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          w_start,
    input  axi_burst_pkg::user_cmd_t      w_cmd,
    input  axi_burst_pkg::fifo_cnt_t      w_fifo_cnt,
    input  logic                          seg_ready,
    input  logic                          seg_done,
    input  axi_burst_pkg::axi_resp_e      seg_resp,
    output logic                          w_free,
    output axi_burst_pkg::cmd_err_t       w_cmd_error,
    output axi_burst_pkg::axi_resp_e      w_status,
    output axi_burst_pkg::burst_seg_t     seg,
    output logic                          seg_valid
);

    // wide enough for a full page of beats
    localparam int BEAT_W = `PAGE_SHIFT - `AXI_BEAT_SHIFT + 1;
    localparam logic [BEAT_W-1:0] PAGE_BEATS = BEAT_W'(`PAGE_BYTES >> `AXI_BEAT_SHIFT);

    axi_burst_pkg::planner_state_e  state;
    axi_burst_pkg::planner_state_e  state_nxt;
    axi_burst_pkg::user_cmd_t       cmd_q;
    axi_burst_pkg::burst_seg_t      seg_q;
    axi_burst_pkg::burst_seg_t      next_seg_q;   // part after the boundary
    axi_burst_pkg::cmd_err_t        chk_err;
    logic                           split_q;
    logic                           split;
    logic                           accept;
    logic [BEAT_W-1:0]              beats_to_bnd;
    logic [BEAT_W-1:0]              cmd_beats;
    logic [BEAT_W-1:0]              first_beats;
    logic [BEAT_W-1:0]              rest_len;

    assign w_free    = (state == axi_burst_pkg::PL_IDLE);
    assign accept    = w_start && w_free;
    assign seg_valid = (state == axi_burst_pkg::PL_ISSUE);
    assign seg       = seg_q;

    // page arithmetic on the captured command
    always_comb
    begin
        beats_to_bnd = PAGE_BEATS - BEAT_W'(cmd_q.addr[`PAGE_SHIFT-1:`AXI_BEAT_SHIFT]);
        cmd_beats    = BEAT_W'(cmd_q.len) + BEAT_W'(1);
        split        = (cmd_beats > beats_to_bnd);
        first_beats  = split ? beats_to_bnd : cmd_beats;
        rest_len     = cmd_beats - beats_to_bnd - BEAT_W'(1);   // only used when split

        chk_err.misaligned = |cmd_q.addr[`AXI_BEAT_SHIFT-1:0];
        chk_err.short_data = (BEAT_W'(w_fifo_cnt) < cmd_beats); // whole burst must be queued
    end

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            axi_burst_pkg::PL_IDLE:
            begin
                if (w_start)
                    state_nxt = axi_burst_pkg::PL_CHECK;
            end
            axi_burst_pkg::PL_CHECK:
            begin
                if (|chk_err)
                    state_nxt = axi_burst_pkg::PL_IDLE;
                else
                    state_nxt = axi_burst_pkg::PL_ISSUE;
            end
            axi_burst_pkg::PL_ISSUE:
            begin
                if (seg_ready)
                    state_nxt = axi_burst_pkg::PL_WAIT;
            end
            axi_burst_pkg::PL_WAIT:
            begin
                if (seg_done)
                    state_nxt = split_q ? axi_burst_pkg::PL_ISSUE : axi_burst_pkg::PL_IDLE;
            end
            default: state_nxt = axi_burst_pkg::PL_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state       <= axi_burst_pkg::PL_IDLE;
            split_q     <= 1'b0;
            w_cmd_error <= '0;
            w_status    <= axi_burst_pkg::OKAY;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
            begin
                w_cmd_error <= '0;
                w_status    <= axi_burst_pkg::OKAY;
            end
            if (state == axi_burst_pkg::PL_CHECK)
            begin
                w_cmd_error <= chk_err;
                split_q     <= split && !(|chk_err);
            end
            if (state == axi_burst_pkg::PL_WAIT && seg_done)
                split_q <= 1'b0;
            // first bad response of the command sticks
            if (seg_done && w_status == axi_burst_pkg::OKAY)
                w_status <= seg_resp;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
            cmd_q <= w_cmd;

        if (state == axi_burst_pkg::PL_CHECK)
        begin
            seg_q.addr      <= cmd_q.addr;
            seg_q.len       <= axi_burst_pkg::len_t'(first_beats - BEAT_W'(1));
            next_seg_q.addr <= {cmd_q.addr[`AXI_ADDR_W-1:`PAGE_SHIFT] + 1'b1,
                                {`PAGE_SHIFT{1'b0}}};
            next_seg_q.len  <= axi_burst_pkg::len_t'(rest_len);
        end
        else if (state == axi_burst_pkg::PL_WAIT && seg_done && split_q)
        begin
            seg_q <= next_seg_q;    // second half starts at the boundary
        end
    end

endmodule

//--- rtl/axi_burst_pkg.sv
package axi_burst_pkg;

`include "axi_burst_consts.svh"

    typedef logic [`AXI_ADDR_W-1:0]  addr_t;
    typedef logic [`AXI_LEN_W-1:0]   len_t;     // beats minus one
    typedef logic [`AXI_DATA_W-1:0]  data_t;
    typedef logic [`AXI_STRB_W-1:0]  strb_t;
    typedef logic [`FIFO_CNT_W-1:0]  fifo_cnt_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } user_cmd_t;

    // one AXI burst, never crosses a page
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_seg_t;

    // shared by AW and AR
    typedef struct packed {
        addr_t       addr;
        len_t        len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [3:0]  cache;
        logic [2:0]  prot;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic short_data;   // FIFO holds less than the burst
        logic misaligned;   // address not on a beat boundary
    } cmd_err_t;

    typedef enum logic [3:0] {
        PL_IDLE  = 4'b0001,
        PL_CHECK = 4'b0010,
        PL_ISSUE = 4'b0100,
        PL_WAIT  = 4'b1000
    } planner_state_e;

    // idle is the all-zero code
    typedef enum logic [2:0] {
        W_IDLE = 3'b000,
        W_ADDR = 3'b001,
        W_DATA = 3'b010,
        W_RESP = 3'b100
    } wr_state_e;

    typedef enum logic [2:0] {
        R_IDLE = 3'b001,
        R_ADDR = 3'b010,
        R_DATA = 3'b100
    } rd_state_e;

endpackage

//--- rtl/axi_burst_consts.svh
`ifndef AXI_BURST_CONSTS_SVH
`define AXI_BURST_CONSTS_SVH

// bus widths
`define AXI_ADDR_W          32
`define AXI_DATA_W          64
`define AXI_STRB_W          8
`define AXI_LEN_W           8      // AXI4 length field
`define AXI_BEAT_SHIFT      3      // log2 of bytes per beat

// bursts must not cross a page
`define PAGE_BYTES          4096
`define PAGE_SHIFT          12

// user FIFO count, holds up to 256 beats
`define FIFO_CNT_W          9

// fixed AXI attributes
`define AXI_BURST_INCR      2'b01
`define AXI_CACHE_DEFAULT   4'b0011  // normal non-cacheable bufferable
`define AXI_PROT_DEFAULT    3'b000   // unprivileged, secure, data

`endif
